//--- hw/vic_macros.svh
`ifndef VIC_MACROS_SVH
`define VIC_MACROS_SVH

// --------------------------------------------------------------------------
// PAL 6569 frame limits
// --------------------------------------------------------------------------
// last pixel of a line, 504 pixels
`define RASTER_X_MAX 503
// last line of a frame, 312 lines
`define RASTER_LINE_MAX 311

// --------------------------------------------------------------------------
// phase timing and bus-cycle stretches
// --------------------------------------------------------------------------
// dot4x ticks per phi phase
`define PHASE_TICKS 16
// tick inside phi high where cpu write data is taken
`define REG_DAV 7
// idle count where HI goes back to LP
`define IDLE_STRETCH 2
// dram refresh slots per line
`define REFRESH_SLOTS 5
// line cycle where graphics slots end
`define GRAPHICS_LAST_CYCLE 54
// refresh row at frame start
`define REFC_RESET 8'hFF
// address driven in slots without a fetch
`define ADDR_IDLE 14'h3FFF

// --------------------------------------------------------------------------
// register offsets
// --------------------------------------------------------------------------
`define REG_RASTER_CTRL 6'd17
`define REG_RASTER_LINE 6'd18
`define REG_IRQ_STATUS 6'd25
`define REG_IRQ_ENABLE 6'd26
`define REG_BORDER_COLOR 6'd32

`endif

//--- hw/vicPkg.sv
`default_nettype none

package vicPkg;

  // pixel position within a line
  typedef logic [9:0] rasterXT;
  // raster line within a frame
  typedef logic [8:0] rasterLineT;
  // dot4x tick within a phi phase
  typedef logic [3:0] phaseTickT;
  // dram refresh row
  typedef logic [7:0] refreshT;
  // multiplexed address bus out
  typedef logic [11:0] vicAddrT;
  // cpu register offset
  typedef logic [5:0] regAddrT;
  // data bus, colour nibble on top
  typedef logic [11:0] dataBusT;
  // colour index
  typedef logic [3:0] vicColorT;

  // bus slots, L = phi low, H = phi high
  typedef enum logic [3:0] {
    LP, HPI1, LPI2, HPI3, LR, HRI, HRX, LG, HGI, HI, LI
  } busCycleT;

endpackage : vicPkg

`default_nettype wire

//--- hw/phaseTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_macros.svh"

module phaseTimer (
  input  wire               clk_dot4x,
  input  wire               rst,
  output logic              dotRise,
  output logic              clkPhi,
  output vicPkg::phaseTickT phaseTick
);

  // one bit set every fourth position, rotated each tick
  logic [15:0] dotPattern;
  logic        phaseLast;

  // last tick before phi flips
  assign phaseLast = (phaseTick == 4'(`PHASE_TICKS - 1));

  // bit 15 set means a dot strobe on the next tick
  assign dotRise = dotPattern[0];

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotPattern <= 16'b1000_1000_1000_1000;
    end else begin
      dotPattern <= {dotPattern[14:0], dotPattern[15]};
    end
  end

  // start a quarter of the way into phi low
  // dot strobes then land on ticks 0, 4, 8 and 12
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      phaseTick <= 4'd3;
      clkPhi    <= 1'b0;
    end else if (phaseLast) begin
      phaseTick <= '0;
      clkPhi    <= ~clkPhi;
    end else begin
      phaseTick <= phaseTick + 4'd1;
    end
  end

endmodule : phaseTimer

`default_nettype wire

//--- hw/rasterCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_macros.svh"

module rasterCounter (
  input  wire                clk_dot4x,
  input  wire                rst,
  input  wire                dotRise,
  output vicPkg::rasterXT    rasterX,
  output vicPkg::rasterLineT rasterLine
);

  logic lineEnd;
  logic frameEnd;

  // last pixel of the line
  assign lineEnd = (rasterX == vicPkg::rasterXT'(`RASTER_X_MAX));
  // last line of the frame
  assign frameEnd = (rasterLine == vicPkg::rasterLineT'(`RASTER_LINE_MAX));

  // --------------------------------------------------------------------------
  // pixel counter
  // --------------------------------------------------------------------------
  // one step per dot strobe, 504 pixels per line
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX <= '0;
    end else if (dotRise) begin
      if (lineEnd) begin
        rasterX <= '0;
      end else begin
        rasterX <= rasterX + 10'd1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // line counter
  // --------------------------------------------------------------------------
  // steps together with the pixel wrap
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterLine <= '0;
    end else if (dotRise && lineEnd) begin
      if (frameEnd) begin
        rasterLine <= '0;
      end else begin
        rasterLine <= rasterLine + 9'd1;
      end
    end
  end

endmodule : rasterCounter

`default_nettype wire

//--- hw/busCycleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_macros.svh"

module busCycleSequencer (
  input  wire               clk_dot4x,
  input  wire               rst,
  input  wire               clkPhi,
  input  vicPkg::phaseTickT phaseTick,
  input  vicPkg::rasterXT   rasterX,
  output vicPkg::busCycleT  vicCycle,
  output vicPkg::busCycleT  nextCycle
);

  // stretch counters for sprite, refresh and idle runs
  logic [2:0] spriteCnt;
  logic [2:0] refreshCnt;
  logic [2:0] idleCnt;
  // 8 pixels per line cycle
  logic [6:0] cycleNum;

  assign cycleNum = rasterX[9:3];

  // --------------------------------------------------------------------------
  // next slot, decided one tick before the phase ends
  // --------------------------------------------------------------------------
  // line starts inside the pointer slot of sprite 3
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      nextCycle  <= vicPkg::LP;
      spriteCnt  <= 3'd3;
      refreshCnt <= '0;
      idleCnt    <= '0;
    end else if (phaseTick == 4'(`PHASE_TICKS - 2)) begin
      if (!clkPhi) begin
        // phi high comes next
        case (vicCycle)
          vicPkg::LP:   nextCycle <= vicPkg::HPI1;
          vicPkg::LPI2: nextCycle <= vicPkg::HPI3;
          vicPkg::LR: begin
            if (refreshCnt == 3'(`REFRESH_SLOTS - 1)) begin
              nextCycle <= vicPkg::HRX;
            end else begin
              nextCycle <= vicPkg::HRI;
            end
          end
          vicPkg::LG: begin
            if (cycleNum == 7'(`GRAPHICS_LAST_CYCLE)) begin
              nextCycle <= vicPkg::HI;
              idleCnt   <= '0;
            end else begin
              nextCycle <= vicPkg::HGI;
            end
          end
          vicPkg::LI:   nextCycle <= vicPkg::HI;
          default:      nextCycle <= vicPkg::LP;
        endcase
      end else begin
        // phi low comes next
        case (vicCycle)
          vicPkg::HPI1: nextCycle <= vicPkg::LPI2;
          vicPkg::HPI3: begin
            // eight sprite pointer slots, then refresh
            if (spriteCnt == 3'd7) begin
              nextCycle  <= vicPkg::LR;
              spriteCnt  <= '0;
              refreshCnt <= '0;
            end else begin
              nextCycle <= vicPkg::LP;
              spriteCnt <= spriteCnt + 3'd1;
            end
          end
          vicPkg::HRI: begin
            nextCycle  <= vicPkg::LR;
            refreshCnt <= refreshCnt + 3'd1;
          end
          vicPkg::HRX, vicPkg::HGI: nextCycle <= vicPkg::LG;
          vicPkg::HI: begin
            if (idleCnt == 3'(`IDLE_STRETCH)) begin
              nextCycle <= vicPkg::LP;
            end else begin
              nextCycle <= vicPkg::LI;
              idleCnt   <= idleCnt + 3'd1;
            end
          end
          default: nextCycle <= vicPkg::LP;
        endcase
      end
    end
  end

  // current slot takes over on the last tick of the phase
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vicCycle <= vicPkg::LP;
    end else if (phaseTick == 4'(`PHASE_TICKS - 1)) begin
      vicCycle <= nextCycle;
    end
  end

endmodule : busCycleSequencer

`default_nettype wire

//--- hw/dramStrobes.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_macros.svh"

module dramStrobes (
  input  wire                clk_dot4x,
  input  wire                rst,
  input  wire                clkPhi,
  input  vicPkg::phaseTickT  phaseTick,
  input  vicPkg::rasterXT    rasterX,
  input  vicPkg::rasterLineT rasterLine,
  input  vicPkg::busCycleT   vicCycle,
  input  vicPkg::busCycleT   nextCycle,
  output logic               ras,
  output logic               cas,
  output logic               mux,
  output vicPkg::vicAddrT    ado
);

  // bit 15 is the strobe level, shifted left once per tick
  // ras falls at tick 5, cas at tick 7
  localparam logic [15:0] RasProfile = 16'b1111_1000_0000_0000;
  localparam logic [15:0] CasProfile = 16'b1111_1110_0000_0000;
  localparam logic [15:0] HoldHigh   = 16'hFFFF;

  logic [15:0]     rasShift;
  logic [15:0]     casShift;
  logic [15:0]     muxShift;
  logic            phaseEnd;
  logic            noAccess;
  logic            frameEnd;
  vicPkg::refreshT refc;
  logic [13:0]     fetchAddr;
  logic [7:0]      ado8;

  assign phaseEnd = (phaseTick == 4'(`PHASE_TICKS - 1));
  // idle phi-low slots get no dram access at all
  assign noAccess = clkPhi && (nextCycle == vicPkg::LPI2 || nextCycle == vicPkg::LI);
  assign frameEnd = (rasterX == vicPkg::rasterXT'(`RASTER_X_MAX)) &&
                    (rasterLine == vicPkg::rasterLineT'(`RASTER_LINE_MAX));

  // --------------------------------------------------------------------------
  // strobe profiles, loaded on the last tick of each phase
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasShift <= HoldHigh;
      casShift <= HoldHigh;
      muxShift <= HoldHigh;
    end else if (phaseEnd) begin
      rasShift <= noAccess ? HoldHigh : RasProfile;
      casShift <= noAccess ? HoldHigh : CasProfile;
      // refresh is row-only, so the address never switches to column
      if (noAccess || (clkPhi && nextCycle == vicPkg::LR)) begin
        muxShift <= HoldHigh;
      end else begin
        muxShift <= RasProfile;
      end
    end else begin
      rasShift <= {rasShift[14:0], 1'b0};
      casShift <= {casShift[14:0], 1'b0};
      muxShift <= {muxShift[14:0], 1'b0};
    end
  end

  assign ras = rasShift[15];
  assign cas = casShift[15];
  assign mux = muxShift[15];

  // one row per refresh slot, counting down across the frame
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      refc <= `REFC_RESET;
    end else if (phaseEnd) begin
      if (vicCycle == vicPkg::LR) begin
        refc <= refc - 8'd1;
      end else if (frameEnd) begin
        refc <= `REFC_RESET;
      end
    end
  end

  // --------------------------------------------------------------------------
  // address out
  // --------------------------------------------------------------------------
  always_comb begin
    if (vicCycle == vicPkg::LR) begin
      fetchAddr = {6'h3F, refc};
    end else begin
      fetchAddr = `ADDR_IDLE;
    end
  end

  // row byte while mux is high, column byte one tick after mux falls
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ado8 <= 8'hFF;
    end else begin
      ado8 <= mux ? fetchAddr[7:0] : {2'b11, fetchAddr[13:8]};
    end
  end

  assign ado = {fetchAddr[11:8], ado8};

endmodule : dramStrobes

`default_nettype wire

//--- hw/vicRegisters.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_macros.svh"

module vicRegisters (
  input  wire                clk_dot4x,
  input  wire                rst,
  input  wire                clkPhi,
  input  vicPkg::phaseTickT  phaseTick,
  input  vicPkg::rasterXT    rasterX,
  input  vicPkg::rasterLineT rasterLine,
  input  vicPkg::regAddrT    adi,
  input  vicPkg::dataBusT    dbi,
  input  wire                ce,
  input  wire                rw,
  output vicPkg::dataBusT    dbo,
  output logic               irq
);

  vicPkg::rasterLineT rasterCmp;
  vicPkg::vicColorT   borderColor;
  logic               rasterEn;
  logic               rasterLatch;
  logic               rasterHit;
  logic               rasterHitD;
  logic               regWrite;
  logic               latchClr;
  logic [7:0]         readByte;

  // cpu write data is stable at this tick of phi high
  assign regWrite = clkPhi && !ce && !rw && (phaseTick == 4'(`REG_DAV));
  // writing 1 to status bit 0 acknowledges the raster interrupt
  assign latchClr = regWrite && (adi == `REG_IRQ_STATUS) && dbi[0];

  // --------------------------------------------------------------------------
  // raster compare
  // --------------------------------------------------------------------------
  // line 0 matches in cycle 1 (pixel 8), every other line in cycle 0
  assign rasterHit = (rasterLine == rasterCmp) &&
                     ((rasterLine == '0) ? (rasterX == 10'd8) : (rasterX == '0));

  // latch on the first pixel of the match only
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterHitD  <= 1'b0;
      rasterLatch <= 1'b0;
    end else begin
      rasterHitD <= rasterHit;
      if (rasterHit && !rasterHitD) begin
        rasterLatch <= 1'b1;
      end else if (latchClr) begin
        rasterLatch <= 1'b0;
      end
    end
  end

  assign irq = rasterLatch & rasterEn;

  // --------------------------------------------------------------------------
  // register writes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterCmp   <= '0;
      rasterEn    <= 1'b0;
      borderColor <= '0;
    end else if (regWrite) begin
      case (adi)
        // bit 7 is compare bit 8
        `REG_RASTER_CTRL:  rasterCmp[8] <= dbi[7];
        `REG_RASTER_LINE:  rasterCmp[7:0] <= dbi[7:0];
        `REG_IRQ_ENABLE:   rasterEn <= dbi[0];
        `REG_BORDER_COLOR: borderColor <= dbi[3:0];
        default: ;
      endcase
    end
  end

  // reads see the live line, not the compare value
  always_comb begin
    case (adi)
      `REG_RASTER_CTRL:  readByte = {rasterLine[8], 7'h7F};
      `REG_RASTER_LINE:  readByte = rasterLine[7:0];
      `REG_IRQ_STATUS:   readByte = {irq, 6'h3F, rasterLatch};
      `REG_IRQ_ENABLE:   readByte = {7'h7F, rasterEn};
      `REG_BORDER_COLOR: readByte = {4'hF, borderColor};
      default:           readByte = 8'hFF;
    endcase
  end

  // unused upper nibble of the bus reads as 1s
  always_ff @(posedge clk_dot4x) begin
    if (!ce && rw) begin
      dbo <= {4'hF, readByte};
    end
  end

endmodule : vicRegisters

`default_nettype wire

//--- hw/vicTop.sv
`timescale 1ns/1ps
`default_nettype none

module vicTop (
  input  wire              clk_dot4x,
  input  wire              rst,
  input  vicPkg::regAddrT  adi,
  input  vicPkg::dataBusT  dbi,
  input  wire              ce,
  input  wire              rw,
  output vicPkg::dataBusT  dbo,
  output logic             irq,
  output logic             ras,
  output logic             cas,
  output logic             mux,
  output logic             clkPhi,
  output vicPkg::vicAddrT  ado
);

  logic               dotRise;
  vicPkg::phaseTickT  phaseTick;
  vicPkg::rasterXT    rasterX;
  vicPkg::rasterLineT rasterLine;
  vicPkg::busCycleT   vicCycle;
  vicPkg::busCycleT   nextCycle;

  // --------------------------------------------------------------------------
  // timing
  // --------------------------------------------------------------------------
  phaseTimer uPhaseTimer (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .dotRise   (dotRise),
    .clkPhi    (clkPhi),
    .phaseTick (phaseTick)
  );

  rasterCounter uRasterCounter (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .dotRise    (dotRise),
    .rasterX    (rasterX),
    .rasterLine (rasterLine)
  );

  // --------------------------------------------------------------------------
  // memory bus
  // --------------------------------------------------------------------------
  busCycleSequencer uBusCycleSequencer (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .clkPhi    (clkPhi),
    .phaseTick (phaseTick),
    .rasterX   (rasterX),
    .vicCycle  (vicCycle),
    .nextCycle (nextCycle)
  );

  dramStrobes uDramStrobes (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .clkPhi     (clkPhi),
    .phaseTick  (phaseTick),
    .rasterX    (rasterX),
    .rasterLine (rasterLine),
    .vicCycle   (vicCycle),
    .nextCycle  (nextCycle),
    .ras        (ras),
    .cas        (cas),
    .mux        (mux),
    .ado        (ado)
  );

  // cpu side
  vicRegisters uVicRegisters (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .clkPhi     (clkPhi),
    .phaseTick  (phaseTick),
    .rasterX    (rasterX),
    .rasterLine (rasterLine),
    .adi        (adi),
    .dbi        (dbi),
    .ce         (ce),
    .rw         (rw),
    .dbo        (dbo),
    .irq        (irq)
  );

endmodule : vicTop

`default_nettype wire

//--- tests/tbVic.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_macros.svh"

module tbVic;

  // one raster line in dot4x ticks, 63 phi cycles of 32 ticks
  localparam int LineTicks  = 2016;
  localparam int PhiTimeout = 64;
  localparam int FrameLines = `RASTER_LINE_MAX + 1;
  // both bytes of the idle address are all ones
  localparam logic [7:0] IdleByte = 8'(`ADDR_IDLE);

  logic              clk_dot4x;
  logic              rst;
  vicPkg::regAddrT   adi;
  vicPkg::dataBusT   dbi;
  logic              ce;
  logic              rw;
  vicPkg::dataBusT   dbo;
  logic              irq;
  logic              ras;
  logic              cas;
  logic              mux;
  logic              clkPhi;
  vicPkg::vicAddrT   ado;

  integer seed;
  integer checkCount;
  integer errorCount;
  integer timeoutCount;

  vicTop i_dut (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .adi       (adi),
    .dbi       (dbi),
    .ce        (ce),
    .rw        (rw),
    .dbo       (dbo),
    .irq       (irq),
    .ras       (ras),
    .cas       (cas),
    .mux       (mux),
    .clkPhi    (clkPhi),
    .ado       (ado)
  );

  // 25 MHz dot4x
  always #20 clk_dot4x = ~clk_dot4x;

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic checkData(input string name, input vicPkg::dataBusT got,
                           input vicPkg::dataBusT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkAddr(input string name, input vicPkg::vicAddrT got,
                           input vicPkg::vicAddrT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic reportFault(input string msg);
    errorCount++;
    $display("error at t=%0t: %s", $time, msg);
  endtask

  // --------------------------------------------------------------------------
  // bus helpers
  // --------------------------------------------------------------------------
  task automatic waitPhi(input logic level);
    int ticks;
    ticks = 0;
    while (clkPhi !== level && ticks < PhiTimeout) begin
      @(negedge clk_dot4x);
      ticks++;
    end
    if (clkPhi !== level) begin
      timeoutCount++;
      $display("timeout at t=%0t: clkPhi never reached %b", $time, level);
    end
  endtask

  // cpu write spans one full phi-high phase
  task automatic writeReg(input vicPkg::regAddrT addr, input vicPkg::dataBusT data);
    waitPhi(1'b0);
    waitPhi(1'b1);
    adi = addr;
    dbi = data;
    ce  = 1'b0;
    rw  = 1'b0;
    waitPhi(1'b0);
    ce = 1'b1;
    rw = 1'b1;
  endtask

  // dbo follows one tick after the read is presented
  task automatic readReg(input vicPkg::regAddrT addr, output vicPkg::dataBusT data);
    @(negedge clk_dot4x);
    adi = addr;
    ce  = 1'b0;
    rw  = 1'b1;
    @(negedge clk_dot4x);
    data = dbo;
    ce   = 1'b1;
  endtask

  task automatic readLine(output vicPkg::rasterLineT line);
    vicPkg::dataBusT hi;
    vicPkg::dataBusT lo;
    vicPkg::dataBusT hiAgain;
    readReg(`REG_RASTER_CTRL, hi);
    readReg(`REG_RASTER_LINE, lo);
    readReg(`REG_RASTER_CTRL, hiAgain);
    // line bit 8 moved between reads, low byte is stale
    if (hi[7] != hiAgain[7]) begin
      readReg(`REG_RASTER_LINE, lo);
    end
    line = {hiAgain[7], lo[7:0]};
  endtask

  task automatic setCompare(input vicPkg::rasterLineT cmp);
    writeReg(`REG_RASTER_CTRL, {4'h0, cmp[8], 7'h00});
    writeReg(`REG_RASTER_LINE, {4'h0, cmp[7:0]});
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic testReset;
    rst = 1'b1;
    repeat (3) @(negedge clk_dot4x);
    // dram strobes idle high, no interrupt
    checkBit("ras", ras, 1'b1);
    checkBit("cas", cas, 1'b1);
    checkBit("mux", mux, 1'b1);
    checkBit("irq", irq, 1'b0);
    // phi starts in its low phase
    checkBit("clkPhi", clkPhi, 1'b0);
    rst = 1'b0;
  endtask

  task automatic testRegisters;
    vicPkg::dataBusT wr;
    vicPkg::dataBusT rd;
    repeat (3) begin
      wr = vicPkg::dataBusT'($random(seed));
      writeReg(`REG_BORDER_COLOR, wr);
      readReg(`REG_BORDER_COLOR, rd);
      // colour nibble, everything above reads high
      checkData("dbo border colour", rd, {8'hFF, wr[3:0]});
    end
    wr = vicPkg::dataBusT'($random(seed));
    writeReg(`REG_IRQ_ENABLE, wr);
    readReg(`REG_IRQ_ENABLE, rd);
    checkData("dbo irq enable", rd, {11'h7FF, wr[0]});
  endtask

  task automatic testRasterLine;
    vicPkg::rasterLineT first;
    vicPkg::rasterLineT second;
    int step;
    readLine(first);
    repeat (2 * LineTicks) @(negedge clk_dot4x);
    readLine(second);
    step = (int'(second) - int'(first) + FrameLines) % FrameLines;
    checkCount++;
    // reads are not phase aligned, one line either way is fine
    if (step < 1 || step > 3) begin
      errorCount++;
      $display("FAILED t=%0t rasterLine step got %0d expected 2", $time, step);
    end
  endtask

  task automatic testRasterIrq;
    vicPkg::rasterLineT line;
    vicPkg::dataBusT    rd;
    int                 ticks;
    int                 highTicks;
    readLine(line);
    setCompare(vicPkg::rasterLineT'((int'(line) + 3) % FrameLines));
    // drop any hit left from earlier lines, then enable
    writeReg(`REG_IRQ_STATUS, 12'h001);
    writeReg(`REG_IRQ_ENABLE, 12'h001);
    checkBit("irq", irq, 1'b0);
    ticks = 0;
    while (irq !== 1'b1 && ticks < 5 * LineTicks) begin
      @(negedge clk_dot4x);
      ticks++;
    end
    if (irq !== 1'b1) begin
      timeoutCount++;
      $display("timeout at t=%0t: raster interrupt did not fire within 5 lines", $time);
    end
    readReg(`REG_IRQ_STATUS, rd);
    checkData("dbo irq status", rd, 12'hFFF);
    writeReg(`REG_IRQ_STATUS, 12'h001);
    checkBit("irq", irq, 1'b0);
    // masked: the latch may set but irq must stay low
    writeReg(`REG_IRQ_ENABLE, 12'h000);
    readLine(line);
    setCompare(vicPkg::rasterLineT'((int'(line) + 3) % FrameLines));
    highTicks = 0;
    repeat (5 * LineTicks) begin
      @(negedge clk_dot4x);
      if (irq !== 1'b0) begin
        highTicks++;
      end
    end
    if (highTicks != 0) begin
      reportFault("irq went high while the raster interrupt was disabled");
    end
  endtask

  task automatic testRefresh;
    vicPkg::vicAddrT samples[$];
    vicPkg::vicAddrT prev;
    logic            casLast;
    bit              started;
    bit              havePrev;
    int              runLen;
    int              runs;
    casLast  = cas;
    started  = 1'b0;
    havePrev = 1'b0;
    runLen   = 0;
    runs     = 0;
    prev     = '0;
    // a little over 3 lines so the third run is complete
    repeat (3 * LineTicks + 6 * 32) begin
      @(negedge clk_dot4x);
      if (casLast && !cas && !clkPhi) begin
        samples.push_back(ado);
      end
      casLast = cas;
    end
    foreach (samples[i]) begin
      if (!started) begin
        // skip a run that was cut by the window start
        started = (samples[i][7:0] == IdleByte);
      end else if (runLen > 0 && runLen < `REFRESH_SLOTS) begin
        checkAddr("ado refresh row", samples[i], {4'hF, prev[7:0] - 8'd1});
        prev = samples[i];
        runLen++;
        if (runLen == `REFRESH_SLOTS) begin
          runs++;
        end
      end else if (samples[i][7:0] != IdleByte) begin
        if (runLen == `REFRESH_SLOTS) begin
          reportFault("more refresh slots in a row than one line holds");
        end
        // next line picks up one row below the last one
        if (havePrev) begin
          checkAddr("ado refresh row", samples[i], {4'hF, prev[7:0] - 8'd1});
        end
        prev     = samples[i];
        havePrev = 1'b1;
        runLen   = 1;
      end else begin
        runLen = 0;
      end
    end
    if (runs < 3) begin
      reportFault($sformatf("only %0d complete refresh runs in 3 lines", runs));
    end
  endtask

  task automatic testStrobes;
    logic rasLast;
    logic casLast;
    logic muxLast;
    logic phiLast;
    bit   rasFell;
    bit   rasLow;
    bit   casFell;
    bit   casAfterRas;
    bit   muxFell;
    bit   inPhase;
    int   falls;
    int   idleSlots;
    rasLast     = ras;
    casLast     = cas;
    muxLast     = mux;
    phiLast     = clkPhi;
    rasFell     = 1'b0;
    rasLow      = 1'b0;
    casFell     = 1'b0;
    casAfterRas = 1'b0;
    muxFell     = 1'b0;
    inPhase     = 1'b0;
    falls       = 0;
    idleSlots   = 0;
    repeat (2 * LineTicks) begin
      @(negedge clk_dot4x);
      // phase boundary, judge the phase that just ended
      if (clkPhi !== phiLast) begin
        if (inPhase && rasFell && !casAfterRas) begin
          reportFault("ras fell without a cas fall after it in the same phase");
        end
        // idle phi-low slot, neither cas nor mux moved
        if (inPhase && !phiLast && !muxFell && !casFell) begin
          idleSlots++;
          if (rasLow) begin
            reportFault("ras went low in an idle phi-low slot");
          end
        end
        inPhase     = 1'b1;
        rasFell     = 1'b0;
        rasLow      = 1'b0;
        casFell     = 1'b0;
        casAfterRas = 1'b0;
        muxFell     = 1'b0;
      end
      if (rasLast && !ras) begin
        rasFell = 1'b1;
        falls++;
      end
      if (ras !== 1'b1) begin
        rasLow = 1'b1;
      end
      if (casLast && !cas) begin
        casFell = 1'b1;
        if (rasFell) begin
          casAfterRas = 1'b1;
        end
      end
      if (muxLast && !mux) begin
        muxFell = 1'b1;
      end
      rasLast = ras;
      casLast = cas;
      muxLast = mux;
      phiLast = clkPhi;
    end
    if (falls == 0) begin
      reportFault("no ras fall seen in 2 lines");
    end
    if (idleSlots == 0) begin
      reportFault("no idle phi-low slot seen in 2 lines");
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    clk_dot4x    = 1'b0;
    rst          = 1'b1;
    adi          = '0;
    dbi          = '0;
    ce           = 1'b1;
    rw           = 1'b1;
    seed         = 69980;
    checkCount   = 0;
    errorCount   = 0;
    timeoutCount = 0;

    testReset();
    testRegisters();
    testRasterLine();
    testRasterIrq();
    testRefresh();
    testStrobes();

    $display("checks=%0d errors=%0d timeouts=%0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tbVic

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/vicPkg.sv
hw/phaseTimer.sv
hw/rasterCounter.sv
hw/busCycleSequencer.sv
hw/dramStrobes.sv
hw/vicRegisters.sv
hw/vicTop.sv
tests/tbVic.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tbVic -f vlog.f -o tbVic

./obj_dir/tbVic > sim.log
cat sim.log

if ! grep -qx "Test passed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
